// ==== design/rv_soc_macros.svh ====
`ifndef RV_SOC_MACROS_SVH
`define RV_SOC_MACROS_SVH

// Data word width of the core and both SRAMs
`define RV_XLEN 32

// Words in each SRAM
`define RV_IMEM_DEPTH 256
`define RV_DMEM_DEPTH 256

// Address bit that routes a data access to the I/O port
`define RV_IO_BIT 31

`endif

// ==== design/rv_soc_pkg.sv ====
`default_nettype none

`include "rv_soc_macros.svh"

package rv_soc_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // Control word produced by the decoder
  typedef struct packed {
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    logic                use_imm;
    logic                reg_wen;
    logic                is_load;
    logic                is_store;
    logic                store_byte;
    logic                is_branch;
    logic                branch_ne;
    logic                is_jal;
    logic                is_ebreak;
  } decode_t;

  // Data-side write request for each retired store
  typedef struct packed {
    logic                  wen;
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN/8-1:0] wstrb;
  } dmem_req_t;

endpackage

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_soc_macros.svh"

module rv_decode (
  input  wire logic [`RV_XLEN-1:0] insn,
  output rv_soc_pkg::decode_t      dec,
  output logic                     illegal
);
  import rv_soc_pkg::*;

  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // Sign-extended immediates for each format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    dec     = '0;
    illegal = 1'b0;
    dec.rd  = insn[11:7];
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];

    case (opcode_e'(insn[6:0]))
      OPC_LUI: begin
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ALU_ADD;
          3'b111:  dec.alu_op = ALU_AND;
          3'b110:  dec.alu_op = ALU_OR;
          3'b100:  dec.alu_op = ALU_XOR;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP: begin
        dec.reg_wen = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = ALU_ADD;
          10'b0100000_000: dec.alu_op = ALU_SUB;
          10'b0000000_111: dec.alu_op = ALU_AND;
          10'b0000000_110: dec.alu_op = ALU_OR;
          10'b0000000_100: dec.alu_op = ALU_XOR;
          10'b0000000_010: dec.alu_op = ALU_SLT;
          default:         illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // LW only
        dec.imm     = imm_i;
        dec.alu_op  = ALU_ADD;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
        dec.is_load = 1'b1;
        illegal     = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        dec.imm        = imm_s;
        dec.alu_op     = ALU_ADD;
        dec.use_imm    = 1'b1;
        dec.is_store   = 1'b1;
        dec.store_byte = (funct3 == 3'b000);
        illegal        = (funct3 != 3'b010) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        dec.imm       = imm_b;
        dec.alu_op    = ALU_SUB;
        dec.is_branch = 1'b1;
        dec.branch_ne = funct3[0];
        illegal       = (funct3[2:1] != 2'b00);
      end
      OPC_JAL: begin
        dec.imm     = imm_j;
        dec.reg_wen = 1'b1;
        dec.is_jal  = 1'b1;
      end
      OPC_SYSTEM: begin
        dec.is_ebreak = (insn == 32'h0010_0073);
        illegal       = !dec.is_ebreak;
      end
      default: illegal = 1'b1;
    endcase

    // An illegal word must never look like a writer
    if (illegal) begin
      dec.reg_wen  = 1'b0;
      dec.is_store = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_soc_macros.svh"

module rv_alu (
  input  wire rv_soc_pkg::alu_op_e op,
  input  wire logic [`RV_XLEN-1:0] a,
  input  wire logic [`RV_XLEN-1:0] b,
  output logic [`RV_XLEN-1:0]      result,
  output logic                     zero
);
  import rv_soc_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_AND:    result = a & b;
      ALU_OR:     result = a | b;
      ALU_XOR:    result = a ^ b;
      // Signed compare giving 0 or 1
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Branch equality test after SUB
  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_soc_macros.svh"

module rv_regfile (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic [4:0]          rs1,
  input  wire logic [4:0]          rs2,
  output logic [`RV_XLEN-1:0]      rdata1,
  output logic [`RV_XLEN-1:0]      rdata2,
  input  wire logic                wen,
  input  wire logic [4:0]          rd,
  input  wire logic [`RV_XLEN-1:0] wdata
);

  // Storage for x1..x31 only
  logic [`RV_XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_soc_macros.svh"

module rv_core (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                run,
  output logic [`RV_XLEN-1:0]      imem_raddr,
  input  wire logic [`RV_XLEN-1:0] imem_rdata,
  output logic [`RV_XLEN-1:0]      dmem_raddr,
  input  wire logic [`RV_XLEN-1:0] dmem_rdata,
  output rv_soc_pkg::dmem_req_t    dmem_req,
  output logic                     ebreak,
  output logic                     trap
);
  import rv_soc_pkg::*;

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_next;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_target;
  logic                ebreak_q;
  logic                trap_q;

  decode_t             dec;
  logic                illegal;

  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic                alu_zero;

  logic                active;
  logic                halt_now;
  logic                retire;
  logic                branch_taken;
  logic                rf_wen;
  logic [`RV_XLEN-1:0] rf_wdata;

  assign imem_raddr = pc;

  rv_decode u_decode (
    .insn    (imem_rdata),
    .dec     (dec),
    .illegal (illegal)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (dec.rs1),
    .rs2    (dec.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .wen    (rf_wen),
    .rd     (dec.rd),
    .wdata  (rf_wdata)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op     (dec.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // One instruction retires per enabled cycle unless it halts
  assign active   = run && !ebreak_q && !trap_q;
  assign halt_now = illegal || dec.is_ebreak;
  assign retire   = active && !halt_now;

  // Next PC
  assign pc_plus4     = pc + `RV_XLEN'd4;
  assign pc_target    = pc + dec.imm;
  assign branch_taken = dec.is_branch && (alu_zero ^ dec.branch_ne);
  assign pc_next      = (dec.is_jal || branch_taken) ? pc_target : pc_plus4;

  // Effective address comes out of the ALU as rs1 + imm
  assign dmem_raddr = alu_result;

  always_comb begin
    dmem_req      = '0;
    dmem_req.wen  = retire && dec.is_store;
    dmem_req.addr = alu_result;
    if (dec.store_byte) begin
      // Byte lane picked by the low address bits
      dmem_req.wdata = {4{rs2_data[7:0]}};
      dmem_req.wstrb = 4'b0001 << alu_result[1:0];
    end else begin
      dmem_req.wdata = rs2_data;
      dmem_req.wstrb = 4'b1111;
    end
  end

  // Writeback select
  always_comb begin
    if (dec.is_jal) begin
      rf_wdata = pc_plus4;
    end else if (dec.is_load) begin
      rf_wdata = dmem_rdata;
    end else begin
      rf_wdata = alu_result;
    end
  end

  assign rf_wen = retire && dec.reg_wen;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= '0;
      ebreak_q <= 1'b0;
      trap_q   <= 1'b0;
    end else if (active) begin
      if (halt_now) begin
        // PC holds from here until reset
        ebreak_q <= dec.is_ebreak;
        trap_q   <= illegal;
      end else begin
        pc <= pc_next;
      end
    end
  end

  assign ebreak = ebreak_q;
  assign trap   = trap_q;

endmodule

`default_nettype wire

// ==== design/mem_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_soc_macros.svh"

module mem_sram #(
  parameter int DEPTH = 256
) (
  input  wire logic                  clk,
  input  wire logic [`RV_XLEN-1:0]   rd_addr,
  output logic [`RV_XLEN-1:0]        rd_data,
  input  wire logic                  wr_en,
  input  wire logic [`RV_XLEN-1:0]   wr_addr,
  input  wire logic [`RV_XLEN-1:0]   wr_data,
  input  wire logic [`RV_XLEN/8-1:0] wr_strb
);

  localparam int AW = $clog2(DEPTH);

  logic [`RV_XLEN-1:0] mem [DEPTH];
  logic [AW-1:0]       rd_idx;
  logic [AW-1:0]       wr_idx;

  // Word index from the byte address
  assign rd_idx = rd_addr[AW+1:2];
  assign wr_idx = wr_addr[AW+1:2];

  assign rd_data = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `RV_XLEN/8; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_soc_macros.svh"

module rv_soc (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  run,
  input  wire logic                  prog_wen,
  input  wire logic [7:0]            prog_addr,
  input  wire logic [`RV_XLEN-1:0]   prog_data,
  output logic [`RV_XLEN-1:0]        io_raddr,
  input  wire logic [`RV_XLEN-1:0]   io_rdata,
  output logic                       io_wen,
  output logic [`RV_XLEN-1:0]        io_waddr,
  output logic [`RV_XLEN-1:0]        io_wdata,
  output logic [`RV_XLEN/8-1:0]      io_wstrb,
  output logic                       ebreak,
  output logic                       trap
);
  import rv_soc_pkg::*;

  logic [`RV_XLEN-1:0] imem_raddr;
  logic [`RV_XLEN-1:0] imem_rdata;
  logic [`RV_XLEN-1:0] prog_waddr;

  logic [`RV_XLEN-1:0] dmem_raddr;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic [`RV_XLEN-1:0] sram_rdata;
  dmem_req_t           dmem_req;
  logic                sram_wen;

  logic                io_sel_rd;
  logic                io_sel_wr;

  rv_core u_core (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  // The only address decode in the system
  assign io_sel_rd = dmem_raddr[`RV_IO_BIT];
  assign io_sel_wr = dmem_req.addr[`RV_IO_BIT];

  // Reads
  assign io_raddr   = dmem_raddr;
  assign dmem_rdata = io_sel_rd ? io_rdata : sram_rdata;

  // Writes split between SRAM and I/O
  assign sram_wen = dmem_req.wen && !io_sel_wr;
  assign io_wen   = dmem_req.wen && io_sel_wr;
  assign io_waddr = dmem_req.addr;
  assign io_wdata = dmem_req.wdata;
  assign io_wstrb = dmem_req.wstrb;

  // Program port takes a word index
  assign prog_waddr = {{(`RV_XLEN-10){1'b0}}, prog_addr, 2'b00};

  mem_sram #(
    .DEPTH (`RV_IMEM_DEPTH)
  ) u_imem (
    .clk     (clk),
    .rd_addr (imem_raddr),
    .rd_data (imem_rdata),
    .wr_en   (prog_wen),
    .wr_addr (prog_waddr),
    .wr_data (prog_data),
    .wr_strb ('1)
  );

  mem_sram #(
    .DEPTH (`RV_DMEM_DEPTH)
  ) u_dmem (
    .clk     (clk),
    .rd_addr (dmem_raddr),
    .rd_data (sram_rdata),
    .wr_en   (sram_wen),
    .wr_addr (dmem_req.addr),
    .wr_data (dmem_req.wdata),
    .wr_strb (dmem_req.wstrb)
  );

endmodule

`default_nettype wire

// ==== dv/rv_soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_soc_macros.svh"

module rv_soc_tb;
  import rv_soc_pkg::*;

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  localparam int          MAX_CYCLES  = 2000;

  logic        clk;
  logic        arst_n;
  logic        run;
  logic        prog_wen;
  logic [7:0]  prog_addr;
  logic [31:0] prog_data;
  logic [31:0] io_raddr;
  logic [31:0] io_rdata;
  logic        io_wen;
  logic [31:0] io_waddr;
  logic [31:0] io_wdata;
  logic [3:0]  io_wstrb;
  logic        ebreak;
  logic        trap;

  // Program image shared by the loader and the model
  logic [31:0] prog [$];
  logic [31:0] rng_state;

  // Instruction-set model
  logic [31:0] m_pc;
  logic [31:0] m_regs [32];
  logic [31:0] m_mem [`RV_DMEM_DEPTH];
  logic        m_ebreak;
  logic        m_trap;

  // What the DUT should show in the current cycle
  logic        exp_wen;
  logic [31:0] exp_waddr;
  logic [31:0] exp_wdata;
  logic [3:0]  exp_wstrb;
  logic        exp_io_rd;
  logic [31:0] exp_raddr;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  rv_soc u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .prog_wen  (prog_wen),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .io_raddr  (io_raddr),
    .io_rdata  (io_rdata),
    .io_wen    (io_wen),
    .io_waddr  (io_waddr),
    .io_wdata  (io_wdata),
    .io_wstrb  (io_wstrb),
    .ebreak    (ebreak),
    .trap      (trap)
  );

  always #50 clk = ~clk;

  // Fresh I/O read data on every edge
  always @(posedge clk) begin
    io_rdata <= lcg_step(io_rdata);
  end

  task automatic stop_failed();
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, actual,
               expected);
      stop_failed();
    end
  endtask

  task automatic check_idle();
    check_value("io_wen", io_wen, 32'd0);
    check_value("ebreak", ebreak, 32'd0);
    check_value("trap", trap, 32'd0);
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    arst_n   <= 1'b0;
    run      <= 1'b0;
    prog_wen <= 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_idle();
  endtask

  task automatic reset_model();
    m_pc     = '0;
    m_ebreak = 1'b0;
    m_trap   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
  endtask

  // Program goes in while run is low and the core must stay silent
  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      prog_wen  <= 1'b1;
      prog_addr <= i[7:0];
      prog_data <= prog[i];
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    prog_wen <= 1'b0;
    @(negedge clk);
    check_idle();
  endtask

  // Executes the instruction at m_pc and sets the expected outputs
  task automatic model_step();
    logic [31:0] insn;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] res;
    logic [31:0] pc_next;
    logic        wr;
    logic        bad;
    logic        brk;
    int          idx;

    insn    = ((m_pc >> 2) < prog.size()) ? prog[m_pc >> 2] : 32'h0;
    rd      = insn[11:7];
    f3      = insn[14:12];
    a       = m_regs[insn[19:15]];
    b       = m_regs[insn[24:20]];
    imm_i   = {{20{insn[31]}}, insn[31:20]};
    imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    pc_next = m_pc + 32'd4;
    res     = '0;
    wr      = 1'b0;
    bad     = 1'b0;
    brk     = 1'b0;
    exp_wen   = 1'b0;
    exp_io_rd = 1'b0;

    case (insn[6:0])
      OPC_LUI: begin
        res = {insn[31:12], 12'h0};
        wr  = 1'b1;
      end
      OPC_OP_IMM: begin
        wr = 1'b1;
        case (f3)
          3'b000:  res = a + imm_i;
          3'b111:  res = a & imm_i;
          3'b110:  res = a | imm_i;
          3'b100:  res = a ^ imm_i;
          default: bad = 1'b1;
        endcase
      end
      OPC_OP: begin
        wr = 1'b1;
        case ({insn[31:25], f3})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_111: res = a & b;
          10'b0000000_110: res = a | b;
          10'b0000000_100: res = a ^ b;
          10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default:         bad = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        addr = a + imm_i;
        wr   = 1'b1;
        bad  = (f3 != 3'b010);
        if (addr[`RV_IO_BIT]) begin
          exp_io_rd = 1'b1;
          exp_raddr = addr;
          res       = io_rdata;
        end else begin
          res = m_mem[(addr >> 2) % `RV_DMEM_DEPTH];
        end
      end
      OPC_STORE: begin
        addr = a + imm_s;
        if (f3 == 3'b010) begin
          data = b;
          strb = 4'b1111;
        end else begin
          // SB puts the byte on every lane
          data = {4{b[7:0]}};
          strb = 4'b0001 << addr[1:0];
          bad  = (f3 != 3'b000);
        end
        if (!bad && addr[`RV_IO_BIT]) begin
          exp_wen   = 1'b1;
          exp_waddr = addr;
          exp_wdata = data;
          exp_wstrb = strb;
        end else if (!bad) begin
          idx = (addr >> 2) % `RV_DMEM_DEPTH;
          for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
              m_mem[idx][8*i +: 8] = data[8*i +: 8];
            end
          end
        end
      end
      OPC_BRANCH: begin
        bad = (f3 != 3'b000) && (f3 != 3'b001);
        if ((f3 == 3'b000) ? (a == b) : (a != b)) begin
          pc_next = m_pc + imm_b;
        end
      end
      OPC_JAL: begin
        res     = m_pc + 32'd4;
        wr      = 1'b1;
        pc_next = m_pc + imm_j;
      end
      OPC_SYSTEM: begin
        brk = (insn == EBREAK_WORD);
        bad = !brk;
      end
      default: bad = 1'b1;
    endcase

    if (bad) begin
      m_trap    = 1'b1;
      exp_io_rd = 1'b0;
    end else if (brk) begin
      m_ebreak = 1'b1;
    end else begin
      if (wr && rd != 5'd0) begin
        m_regs[rd] = res;
      end
      m_pc = pc_next;
    end
  endtask

  // Runs DUT and model side by side until the halt and checks the quiet cycles after it
  task automatic run_program(input logic expect_trap);
    int   cycles;
    logic done;

    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    run <= 1'b1;
    while (!done) begin
      @(negedge clk);
      cycles++;
      check_value("ebreak", ebreak, m_ebreak);
      check_value("trap", trap, m_trap);
      if (m_ebreak || m_trap) begin
        check_value("io_wen", io_wen, 32'd0);
        done = 1'b1;
      end else if (cycles > MAX_CYCLES) begin
        $display("Timeout: core did not halt within %0d cycles", MAX_CYCLES);
        stop_failed();
      end else begin
        model_step();
        check_value("io_wen", io_wen, exp_wen);
        if (io_wen) begin
          check_value("io_waddr", io_waddr, exp_waddr);
          check_value("io_wdata", io_wdata, exp_wdata);
          check_value("io_wstrb", io_wstrb, exp_wstrb);
        end
        if (exp_io_rd) begin
          check_value("io_raddr", io_raddr, exp_raddr);
        end
      end
    end
    if (m_trap != expect_trap) begin
      $display("Program halted the wrong way, trap was %0b and should be %0b", m_trap,
               expect_trap);
      stop_failed();
    end
    repeat (3) begin
      @(negedge clk);
      check_value("io_wen", io_wen, 32'd0);
      check_value("ebreak", ebreak, m_ebreak);
      check_value("trap", trap, m_trap);
    end
    @(posedge clk);
    run <= 1'b0;
  endtask

  task automatic run_test(input logic expect_trap);
    reset_dut();
    reset_model();
    load_program();
    run_program(expect_trap);
  endtask

  // Random ALU ops followed by every register out to I/O
  task automatic build_alu_program();
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    int          sel;

    prog.delete();
    emit(enc_u(20'h80000, 5'd31));
    for (int i = 0; i < 24; i++) begin
      r   = next_random();
      r2  = next_random();
      rd  = 5'(1 + r[4:0] % 30);
      rs1 = 5'(r[9:5] % 31);
      rs2 = 5'(r[14:10] % 31);
      sel = r2[15:12] % 6;
      case (sel)
        0, 1:    f3 = 3'b000;
        2:       f3 = 3'b111;
        3:       f3 = 3'b110;
        4:       f3 = 3'b100;
        default: f3 = 3'b010;
      endcase
      if (r[17:16] == 2'd0) begin
        emit(enc_u(r2[19:0], rd));
      end else if (r[17:16] == 2'd1 && sel != 1 && sel != 5) begin
        emit(enc_i(r2[11:0], rs1, f3, rd, OPC_OP_IMM));
      end else begin
        emit(enc_r((sel == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
      end
    end
    for (int i = 1; i < 32; i++) begin
      emit(enc_s(12'(4 * i), 5'(i), 5'd31, 3'b010));
    end
    emit(EBREAK_WORD);
  endtask

  // SW and SB merges in data SRAM read back and sent to I/O
  task automatic build_mem_program();
    logic [31:0] r;

    prog.delete();
    emit(enc_u(20'h80000, 5'd31));
    emit(enc_i(12'h100, 5'd0, 3'b000, 5'd30, OPC_OP_IMM));
    for (int i = 1; i <= 8; i++) begin
      r = next_random();
      emit(enc_u(r[31:12], 5'(i)));
      emit(enc_i(r[11:0], 5'(i), 3'b000, 5'(i), OPC_OP_IMM));
    end
    for (int w = 0; w < 4; w++) begin
      emit(enc_s(12'(4 * w), 5'(w + 1), 5'd30, 3'b010));
    end
    for (int k = 0; k < 11; k++) begin
      r = next_random();
      // Last three byte stores go to I/O to show the lane
      emit(enc_s(12'(r[3:0]), 5'(1 + r[7:4] % 8), (k < 8) ? 5'd30 : 5'd31, 3'b000));
    end
    for (int w = 0; w < 4; w++) begin
      emit(enc_i(12'(4 * w), 5'd30, 3'b010, 5'(10 + w), OPC_LOAD));
      emit(enc_s(12'(12'h40 + 4 * w), 5'(10 + w), 5'd31, 3'b010));
    end
    emit(EBREAK_WORD);
  endtask

  task automatic build_io_load_program();
    logic [31:0] r;

    prog.delete();
    emit(enc_u(20'h80000, 5'd31));
    for (int k = 0; k < 6; k++) begin
      r = next_random();
      emit(enc_i({1'b0, r[10:2], 2'b00}, 5'd31, 3'b010, 5'd5, OPC_LOAD));
      emit(enc_s(12'(4 * k), 5'd5, 5'd31, 3'b010));
    end
    emit(EBREAK_WORD);
  endtask

  // Countdown from 5 with counter and link out on every pass
  task automatic build_loop_program();
    prog.delete();
    emit(enc_u(20'h80000, 5'd31));
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    emit(enc_b(13'd8, 5'd0, 5'd0, 3'b001));
    emit(enc_j(21'd8, 5'd2));
    emit(enc_s(12'h7f0, 5'd0, 5'd31, 3'b010));
    emit(enc_s(12'd0, 5'd1, 5'd31, 3'b010));
    emit(enc_s(12'd4, 5'd2, 5'd31, 3'b010));
    emit(enc_i(12'hfff, 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
    emit(enc_b(13'd12, 5'd0, 5'd1, 3'b000));
    emit(enc_b(13'h1fe8, 5'd0, 5'd1, 3'b001));
    emit(enc_s(12'h7f0, 5'd0, 5'd31, 3'b010));
    emit(EBREAK_WORD);
  endtask

  task automatic build_trap_program();
    logic [31:0] r;
    logic [6:0]  opc;

    r = next_random();
    case (r[1:0])
      2'd0:    opc = 7'b0010111;
      2'd1:    opc = 7'b1100111;
      2'd2:    opc = 7'b0001111;
      default: opc = 7'b0000000;
    endcase
    prog.delete();
    emit(enc_u(20'h80000, 5'd31));
    emit(enc_i(r[19:8], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
    emit(enc_s(12'd0, 5'd1, 5'd31, 3'b010));
    emit(enc_s(12'd4, 5'd1, 5'd31, 3'b010));
    emit({r[31:7], opc});
    emit(enc_s(12'd8, 5'd1, 5'd31, 3'b010));
    emit(EBREAK_WORD);
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    run       = 1'b0;
    prog_wen  = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    rng_state = 32'h3a53b82e;
    io_rdata  = lcg_step(32'h3a53b82e);

    repeat (3) begin
      build_alu_program();
      run_test(1'b0);
    end
    repeat (2) begin
      build_mem_program();
      run_test(1'b0);
    end
    build_io_load_program();
    run_test(1'b0);
    build_loop_program();
    run_test(1'b0);
    build_trap_program();
    run_test(1'b1);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_soc.f ====
+incdir+design
design/rv_soc_pkg.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_core.sv
design/mem_sram.sv
design/rv_soc.sv
dv/rv_soc_tb.sv
